/* Bender.yml */
package:
  name: soc_sysctl

sources:
  - source/soc_pkg.sv
  - source/reset_ctrl.sv
  - source/pi1_router.sv
  - source/dev_table.sv
  - source/gpio_port.sv
  - source/scratch_ram.sv
  - source/soc_top.sv
  - target: simulation
    files:
      - dv/soc_tb.sv

/* dv/soc_tb.sv */
// Drives soc_top over the PI1 port; inputs change 1 ns after each rising edge
// GPIO words are checked directly, all other reads against ref_read
`timescale 1ns/10ps

module soc_tb;

	localparam int GPIO_BASE_W = soc_pkg::DEVTBL_MAPSZ;
	localparam int RAM_BASE_W = GPIO_BASE_W + soc_pkg::GPIO_MAPSZ;
	localparam int INV_BASE_W = RAM_BASE_W + soc_pkg::RAM_MAPSZ;
	localparam int BUS_TIMEOUT = 1000;

	logic clk100mhz = 1'b0;
	logic rst_p;
	logic pll_locked_i;
	soc_pkg::pi1_op_e pi1_op_i;
	soc_pkg::addr_t pi1_addr_i;
	soc_pkg::word_t pi1_data_i;
	soc_pkg::sel_t pi1_sel_i;
	soc_pkg::gpio_t gp_i;
	soc_pkg::word_t pi1_data_o;
	logic pi1_rdy_o;
	soc_pkg::gpio_t gp_o;
	logic gpio_irq_o;
	logic activity_o;
	logic sys_rst_o;

	soc_pkg::word_t rng_state = 32'd54837;
	soc_pkg::word_t shadow [soc_pkg::RAM_MAPSZ];
	int cyc = 0;
	int act_last = 0;
	int act_seen = 0;
	bit act_watch = 1'b0;

	soc_top u_dut (
		.clk100mhz(clk100mhz),
		.rst_p(rst_p),
		.pll_locked_i(pll_locked_i),
		.pi1_op_i(pi1_op_i),
		.pi1_addr_i(pi1_addr_i),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i),
		.gp_i(gp_i),
		.pi1_data_o(pi1_data_o),
		.pi1_rdy_o(pi1_rdy_o),
		.gp_o(gp_o),
		.gpio_irq_o(gpio_irq_o),
		.activity_o(activity_o),
		.sys_rst_o(sys_rst_o)
	);

	always #5 clk100mhz = ~clk100mhz;

	// ------------------------------------------------------------
	// Reference model and helpers
	// ------------------------------------------------------------
	function automatic soc_pkg::word_t next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic soc_pkg::word_t apply_sel(soc_pkg::word_t old_w, soc_pkg::word_t new_w,
			soc_pkg::sel_t s);
		soc_pkg::word_t w;
		w = old_w;
		for (int b = 0; b < 4; b++) begin
			if (s[b]) begin
				w[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return w;
	endfunction

	// Only the GPIO slave uses an interrupt
	function automatic soc_pkg::word_t ref_read(soc_pkg::addr_t a);
		int k;
		if (a == 0) begin
			return soc_pkg::SLAVE_COUNT;
		end
		if (a >= 2 && a < 2 + 2 * soc_pkg::SLAVE_COUNT) begin
			k = (a - 2) / 2;
			case (k)
				0: return a[0] ? soc_pkg::DEVTBL_MAPSZ : {16'd0, soc_pkg::DEVTBL_ID};
				1: return a[0] ? soc_pkg::GPIO_MAPSZ : {1'b1, 15'd0, soc_pkg::GPIO_ID};
				2: return a[0] ? soc_pkg::RAM_MAPSZ : {16'd0, soc_pkg::RAM_ID};
				default: return a[0] ? soc_pkg::INVALID_MAPSZ : {16'd0, soc_pkg::INVALID_ID};
			endcase
		end
		if (a >= RAM_BASE_W && a < INV_BASE_W) begin
			return shadow[a - RAM_BASE_W];
		end
		return '0;
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input soc_pkg::word_t got,
			input soc_pkg::word_t exp);
		if (got !== exp) begin
			report_fail($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// ------------------------------------------------------------
	// Bus tasks, entered and left 1 ns after a rising edge
	// ------------------------------------------------------------
	task automatic bus_xfer(input soc_pkg::pi1_op_e op, input soc_pkg::addr_t a,
			input soc_pkg::word_t d, input soc_pkg::sel_t s, output soc_pkg::word_t rd);
		int t;
		pi1_op_i = op;
		pi1_addr_i = a;
		pi1_data_i = d;
		pi1_sel_i = s;
		t = 0;
		#1;
		while (!pi1_rdy_o) begin
			if (t == BUS_TIMEOUT) begin
				report_fail($sformatf("request to address 0x%08h never accepted", a));
			end
			@(posedge clk100mhz);
			#2;
			t++;
		end
		@(posedge clk100mhz);
		#1;
		pi1_op_i = soc_pkg::NOP;
		rd = pi1_data_o;
	endtask

	task automatic bus_write(input int a, input soc_pkg::word_t d, input soc_pkg::sel_t s);
		soc_pkg::word_t unused;
		bus_xfer(soc_pkg::WR, soc_pkg::addr_t'(a), d, s, unused);
	endtask

	task automatic bus_read(input int a, output soc_pkg::word_t rd);
		bus_xfer(soc_pkg::RD, soc_pkg::addr_t'(a), '0, '0, rd);
	endtask

	task automatic bus_swap(input int a, input soc_pkg::word_t d, input soc_pkg::sel_t s,
			output soc_pkg::word_t rd);
		bus_xfer(soc_pkg::RW, soc_pkg::addr_t'(a), d, s, rd);
	endtask

	task automatic read_check(input int a);
		soc_pkg::word_t rd;
		bus_read(a, rd);
		check_word("pi1_data_o", rd, ref_read(soc_pkg::addr_t'(a)));
	endtask

	task automatic wait_sys_rst(input logic level, input int limit, output int n);
		n = 0;
		while (sys_rst_o !== level) begin
			if (n == limit) begin
				report_fail($sformatf("sys_rst_o did not reach %0d within %0d cycles", level, limit));
			end
			@(posedge clk100mhz);
			#1;
			n++;
		end
	endtask

	task automatic zero_shadow();
		for (int i = 0; i < soc_pkg::RAM_MAPSZ; i++) begin
			shadow[i] = '0;
		end
	endtask

	// Activity pulses must be spaced by the hold-off
	always @(negedge clk100mhz) begin
		cyc++;
		if (act_watch && activity_o) begin
			if (act_seen != 0 && cyc - act_last < soc_pkg::ACT_HOLDOFF + 1) begin
				report_fail("activity_o pulsed again before the hold-off expired");
			end
			act_seen++;
			act_last = cyc;
		end
	end

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		soc_pkg::word_t d;
		soc_pkg::word_t rd;
		soc_pkg::sel_t s;
		int a;
		int n;
		int idx_q[$];
		rst_p = 1'b1;
		pll_locked_i = 1'b0;
		pi1_op_i = soc_pkg::NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '0;
		gp_i = '0;
		zero_shadow();
		repeat (4) @(posedge clk100mhz);
		#1;
		pll_locked_i = 1'b1;
		repeat (12) @(posedge clk100mhz);
		#1;
		rst_p = 1'b0;
		check_word("gp_o", 32'(gp_o), '0);
		check_bit("gpio_irq_o", gpio_irq_o, 1'b0);
		check_bit("activity_o", activity_o, 1'b0);
		check_bit("sys_rst_o", sys_rst_o, 1'b1);
		wait_sys_rst(1'b0, 200, n);

		for (int i = 0; i < soc_pkg::DEVTBL_MAPSZ; i++) begin
			read_check(i);
		end

		for (int i = 0; i < 48; i++) begin
			a = next_rand() & 255;
			d = next_rand();
			s = soc_pkg::sel_t'(next_rand());
			bus_write(RAM_BASE_W + a, d, s);
			shadow[a] = apply_sel(shadow[a], d, s);
			idx_q.push_back(a);
		end
		foreach (idx_q[i]) begin
			read_check(RAM_BASE_W + idx_q[i]);
		end
		for (int i = 0; i < 16; i++) begin
			a = next_rand() & 255;
			d = next_rand();
			s = soc_pkg::sel_t'(next_rand());
			bus_swap(RAM_BASE_W + a, d, s, rd);
			check_word("pi1_data_o", rd, shadow[a]);
			shadow[a] = apply_sel(shadow[a], d, s);
			read_check(RAM_BASE_W + a);
		end

		// Invalid writes must not alias into the RAM through the low address bits
		for (int i = 0; i < 16; i++) begin
			a = next_rand() & 32'h3FFF_FFFF;
			if (a < INV_BASE_W) begin
				a = a + INV_BASE_W;
			end
			read_check(a);
			bus_write(a, next_rand(), 4'hF);
			read_check(RAM_BASE_W + ((a - RAM_BASE_W) & 255));
		end

		bus_write(GPIO_BASE_W, 32'h1234_A5C3, 4'b0011);
		check_word("gp_o", 32'(gp_o), 32'h0000_A5C3);
		bus_write(GPIO_BASE_W, 32'h0000_7E00, 4'b0010);
		check_word("gp_o", 32'(gp_o), 32'h0000_7EC3);
		gp_i = 16'h0081;
		n = 0;
		rd = '0;
		while (rd == '0) begin
			if (n == 10) begin
				report_fail("GPIO change flags never set after gp_i changed");
			end
			bus_read(GPIO_BASE_W + 2, rd);
			n++;
		end
		check_word("gpio flags", rd, 32'h0000_0081);
		check_bit("gpio_irq_o", gpio_irq_o, 1'b0);
		bus_read(GPIO_BASE_W, rd);
		check_word("gpio inputs", rd, 32'h0000_0081);
		bus_write(GPIO_BASE_W + 1, 32'h0000_0080, 4'hF);
		check_bit("gpio_irq_o", gpio_irq_o, 1'b1);
		bus_write(GPIO_BASE_W + 2, 32'h0000_0081, 4'hF);
		check_bit("gpio_irq_o", gpio_irq_o, 1'b0);
		bus_read(GPIO_BASE_W + 2, rd);
		check_word("gpio flags", rd, '0);

		// One device table read per cycle, the data of each returns in the next
		act_watch = 1'b1;
		for (int i = 0; i < 400; i++) begin
			a = next_rand() & 15;
			pi1_op_i = soc_pkg::RD;
			pi1_addr_i = soc_pkg::addr_t'(a);
			#1;
			check_bit("pi1_rdy_o", pi1_rdy_o, 1'b1);
			@(posedge clk100mhz);
			#1;
			check_word("pi1_data_o", pi1_data_o, ref_read(soc_pkg::addr_t'(a)));
		end
		pi1_op_i = soc_pkg::NOP;
		act_watch = 1'b0;
		if (act_seen == 0) begin
			report_fail("activity_o never pulsed during back-to-back requests");
		end

		bus_write(1, 32'h0000_0004, 4'hF);
		pi1_addr_i = soc_pkg::addr_t'(RAM_BASE_W);
		n = 0;
		while (pi1_rdy_o) begin
			if (n == 5) begin
				report_fail("RAM rdy did not drop after a clear command");
			end
			@(posedge clk100mhz);
			#1;
			n++;
		end
		zero_shadow();
		for (int i = 0; i < soc_pkg::RAM_MAPSZ; i++) begin
			read_check(RAM_BASE_W + i);
		end

		bus_write(1, 32'h0000_0002, 4'hF);
		wait_sys_rst(1'b1, 5, n);
		wait_sys_rst(1'b0, 200, n);
		check_word("sys_rst_o high cycles", n, soc_pkg::RST_HOLD_CYCLES + 1);
		check_word("gp_o", 32'(gp_o), '0);

		bus_write(1, 32'h0000_0001, 4'hF);
		wait_sys_rst(1'b1, 5, n);
		for (int i = 0; i < 300; i++) begin
			check_bit("sys_rst_o", sys_rst_o, 1'b1);
			@(posedge clk100mhz);
			#1;
		end
		rst_p = 1'b1;
		repeat (16) @(posedge clk100mhz);
		#1;
		rst_p = 1'b0;
		wait_sys_rst(1'b0, 200, n);
		read_check(0);
		read_check(RAM_BASE_W + 5);

		$display("Done: no errors");
		$finish;
	end

endmodule

/* source/dev_table.sv */
// Read-only descriptors of every slave plus the reset command word
// Reset command pulses last one cycle; bit 0 power-off, bit 1 warm, bit 2 RAM clear
`timescale 1ns/10ps

module dev_table (
	input logic clk100mhz,
	input logic rst_p,
	input soc_pkg::pi1_op_e op_i,
	input logic [3:0] addr_lo_i,
	input soc_pkg::word_t data_i,
	output soc_pkg::word_t data_o,
	output logic rst0_o,
	output logic rst1_o,
	output logic rst2_o
);

	localparam logic [3:0] W_COUNT = 4'd0;
	localparam logic [3:0] W_RSTCMD = 4'd1;

	soc_pkg::word_t rd_word;
	logic cmd_we;
	logic rd_en;

	// Word 2k+2 holds the ID and interrupt flag of slave k, word 2k+3 its map size
	always_comb begin
		rd_word = '0;
		if (addr_lo_i == W_COUNT) begin
			rd_word = soc_pkg::word_t'(soc_pkg::SLAVE_COUNT);
		end
		for (int k = 0; k < soc_pkg::SLAVE_COUNT; k++) begin
			if (addr_lo_i == 4'(2 * k + 2)) begin
				rd_word = {soc_pkg::USEINTR[k], 15'd0, soc_pkg::DEV_ID[k]};
			end
			if (addr_lo_i == 4'(2 * k + 3)) begin
				rd_word = soc_pkg::DEV_MAPSZ[k];
			end
		end
	end

	assign rd_en = (op_i == soc_pkg::RD) || (op_i == soc_pkg::RW);
	assign cmd_we = (op_i == soc_pkg::WR) && (addr_lo_i == W_RSTCMD);

	always_ff @(posedge clk100mhz) begin
		if (rd_en) begin
			data_o <= rd_word;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
			rst2_o <= 1'b0;
		end else begin
			rst0_o <= cmd_we && data_i[0];
			rst1_o <= cmd_we && data_i[1];
			rst2_o <= cmd_we && data_i[2];
		end
	end

endmodule

/* source/gpio_port.sv */
// Inputs pass a two-flop synchronizer; a change sets its flag about three cycles later
// Word 0 pins, word 1 interrupt mask, word 2 change flags (write 1 to clear)
`timescale 1ns/10ps

module gpio_port (
	input logic clk100mhz,
	input logic rst_p,
	input soc_pkg::pi1_op_e op_i,
	input logic [1:0] addr_lo_i,
	input soc_pkg::word_t data_i,
	input soc_pkg::sel_t sel_i,
	input soc_pkg::gpio_t gp_i,
	output soc_pkg::word_t data_o,
	output soc_pkg::gpio_t gp_o,
	output logic irq_o
);

	soc_pkg::gpio_t gp_s1;
	soc_pkg::gpio_t gp_s2;
	soc_pkg::gpio_t gp_prev;
	soc_pkg::gpio_t irq_mask;
	soc_pkg::gpio_t flags;
	soc_pkg::gpio_t flag_clr;
	soc_pkg::word_t rd_word;
	logic wr_en;
	logic rd_en;

	always_ff @(posedge clk100mhz) begin
		gp_s1 <= gp_i;
		gp_s2 <= gp_s1;
		gp_prev <= gp_s2;
	end

	assign wr_en = (op_i == soc_pkg::WR) || (op_i == soc_pkg::RW);
	assign rd_en = (op_i == soc_pkg::RD) || (op_i == soc_pkg::RW);
	assign flag_clr = (wr_en && addr_lo_i == 2'd2) ?
		soc_pkg::gpio_t'(data_i & soc_pkg::sel_mask(sel_i)) : '0;

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			gp_o <= '0;
			irq_mask <= '0;
			flags <= '0;
		end else begin
			if (wr_en && addr_lo_i == 2'd0) begin
				gp_o <= soc_pkg::gpio_t'(soc_pkg::merge_bytes(32'(gp_o), data_i, sel_i));
			end
			if (wr_en && addr_lo_i == 2'd1) begin
				irq_mask <= soc_pkg::gpio_t'(soc_pkg::merge_bytes(32'(irq_mask), data_i, sel_i));
			end
			// A fresh edge wins over a clear in the same cycle
			flags <= (flags & ~flag_clr) | (gp_s2 ^ gp_prev);
		end
	end

	always_comb begin
		case (addr_lo_i)
			2'd0: rd_word = 32'(gp_s2);
			2'd1: rd_word = 32'(irq_mask);
			2'd2: rd_word = 32'(flags);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (rd_en) begin
			data_o <= rd_word;
		end
	end

	assign irq_o = |(flags & irq_mask);

endmodule

/* source/pi1_router.sv */
// Single master, no arbitration; the router adds no latency to any slave
// The invalid region is answered here: always ready, reads zero, writes dropped
`timescale 1ns/10ps

module pi1_router (
	input logic clk100mhz,
	input logic rst_p,
	input soc_pkg::pi1_op_e m_op_i,
	input soc_pkg::addr_t m_addr_i,
	input soc_pkg::word_t m_data_i,
	input soc_pkg::sel_t m_sel_i,
	output soc_pkg::word_t m_data_o,
	output logic m_rdy_o,
	output soc_pkg::pi1_op_e s_op_o [soc_pkg::REAL_SLAVE_COUNT],
	input logic [soc_pkg::REAL_SLAVE_COUNT-1:0] s_rdy_i,
	input soc_pkg::word_t s_data_i [soc_pkg::REAL_SLAVE_COUNT],
	output logic activity_o
);

	soc_pkg::slave_idx_t req_idx;
	soc_pkg::slave_idx_t rsp_idx;
	soc_pkg::act_cnt_t act_cnt;
	logic accept;

	// ------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------
	always_comb begin
		if (m_addr_i < soc_pkg::GPIO_BASE) begin
			req_idx = soc_pkg::S_DEVTBL;
		end else if (m_addr_i < soc_pkg::RAM_BASE) begin
			req_idx = soc_pkg::S_GPIO;
		end else if (m_addr_i < soc_pkg::INVALID_BASE) begin
			req_idx = soc_pkg::S_RAM;
		end else begin
			req_idx = soc_pkg::S_INVALID;
		end
	end

	// Only the addressed slave sees the operation
	for (genvar k = 0; k < soc_pkg::REAL_SLAVE_COUNT; k++) begin : g_slave_op
		assign s_op_o[k] = (req_idx == soc_pkg::slave_idx_t'(k)) ? m_op_i : soc_pkg::NOP;
	end

	assign m_rdy_o = (req_idx == soc_pkg::S_INVALID) ? 1'b1 : s_rdy_i[req_idx];
	assign accept = (m_op_i != soc_pkg::NOP) && m_rdy_o;

	// ------------------------------------------------------------
	// Read data return
	// ------------------------------------------------------------
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			rsp_idx <= soc_pkg::S_INVALID;
		end else if (accept) begin
			rsp_idx <= req_idx;
		end
	end

	assign m_data_o = (rsp_idx == soc_pkg::S_INVALID) ? '0 : s_data_i[rsp_idx];

	// ------------------------------------------------------------
	// Activity strobe with hold-off
	// ------------------------------------------------------------
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			act_cnt <= '0;
			activity_o <= 1'b0;
		end else if (act_cnt != '0) begin
			act_cnt <= act_cnt - 1'b1;
			activity_o <= 1'b0;
		end else if (accept) begin
			act_cnt <= soc_pkg::act_cnt_t'(soc_pkg::ACT_HOLDOFF);
			activity_o <= 1'b1;
		end else begin
			activity_o <= 1'b0;
		end
	end

	// Strobes are spaced by at least the hold-off
	a_act_spacing: assert property (
		@(posedge clk100mhz) disable iff (rst_p)
		activity_o |=> !activity_o [*soc_pkg::ACT_HOLDOFF]
	);

endmodule

/* source/reset_ctrl.sv */
// One clock domain only; pll_locked_i is assumed already synchronous to clk100mhz
// A command with both power-off and warm bits set acts as a warm reset
`timescale 1ns/10ps

module reset_ctrl (
	input logic clk100mhz,
	input logic rst_p,
	input logic pll_locked_i,
	input logic poweroff_i,
	input logic warm_i,
	output logic sys_rst_o
);

	soc_pkg::rst_cnt_t hold_cnt;
	logic off_latch;

	// Stretch counter restarts on every cycle of board or warm reset
	always_ff @(posedge clk100mhz) begin
		if (rst_p || warm_i) begin
			hold_cnt <= soc_pkg::rst_cnt_t'(soc_pkg::RST_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Power-off holds the system down until the board reset is pressed
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			off_latch <= 1'b0;
		end else if (poweroff_i && !warm_i) begin
			off_latch <= 1'b1;
		end
	end

	assign sys_rst_o = rst_p || warm_i || !pll_locked_i || off_latch || (hold_cnt != '0);

	// A warm pulse keeps the system in reset for the whole hold window
	a_warm_hold: assert property (
		@(posedge clk100mhz) warm_i |=> sys_rst_o [*soc_pkg::RST_HOLD_CYCLES]
	);

endmodule

/* source/scratch_ram.sv */
// Small word RAM in place of main memory; contents are zeroed after every reset
// rdy_o stays low for RAM_MAPSZ cycles while a clear sweep runs
`timescale 1ns/10ps

module scratch_ram (
	input logic clk100mhz,
	input logic rst_p,
	input logic clear_i,
	input soc_pkg::pi1_op_e op_i,
	input soc_pkg::ram_addr_t addr_lo_i,
	input soc_pkg::word_t data_i,
	input soc_pkg::sel_t sel_i,
	output soc_pkg::word_t data_o,
	output logic rdy_o
);

	soc_pkg::word_t mem [soc_pkg::RAM_MAPSZ];
	soc_pkg::ram_addr_t sweep_cnt;
	logic sweep_act;
	logic accept;

	// The sweep is armed during reset and starts once reset is released
	always_ff @(posedge clk100mhz) begin
		if (rst_p || clear_i) begin
			sweep_act <= 1'b1;
			sweep_cnt <= '0;
		end else if (sweep_act) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (sweep_cnt == soc_pkg::ram_addr_t'(soc_pkg::RAM_MAPSZ - 1)) begin
				sweep_act <= 1'b0;
			end
		end
	end

	assign rdy_o = !sweep_act;
	assign accept = (op_i != soc_pkg::NOP) && rdy_o;

	always_ff @(posedge clk100mhz) begin
		if (sweep_act) begin
			mem[sweep_cnt] <= '0;
		end else if (accept && (op_i == soc_pkg::WR || op_i == soc_pkg::RW)) begin
			mem[addr_lo_i] <= soc_pkg::merge_bytes(mem[addr_lo_i], data_i, sel_i);
		end
	end

	// Swap reads the word before this cycle's write lands
	always_ff @(posedge clk100mhz) begin
		if (accept && (op_i == soc_pkg::RD || op_i == soc_pkg::RW)) begin
			data_o <= mem[addr_lo_i];
		end
	end

	// A stalled request must still be on the bus in the next cycle
	a_stall_hold: assert property (
		@(posedge clk100mhz) disable iff (rst_p || clear_i)
		(op_i != soc_pkg::NOP && !rdy_o) |=> (op_i == $past(op_i) && addr_lo_i == $past(addr_lo_i))
	);

endmodule

/* source/soc_pkg.sv */
// Shared bus types, memory map and constants; the map starts at word address 0
// Slaves are laid out back to back in index order, anything past the RAM is invalid
package soc_pkg;

	// ------------------------------------------------------------
	// PI1 bus types
	// ------------------------------------------------------------
	typedef logic [31:0] word_t;
	typedef logic [29:0] addr_t;
	typedef logic [3:0] sel_t;
	typedef logic [1:0] slave_idx_t;

	// RW is a swap that writes the data and returns the old word
	typedef enum logic [1:0] {
		NOP = 2'd0,
		WR = 2'd1,
		RD = 2'd2,
		RW = 2'd3
	} pi1_op_e;

	// ------------------------------------------------------------
	// Memory map
	// ------------------------------------------------------------
	localparam slave_idx_t S_DEVTBL = 2'd0;
	localparam slave_idx_t S_GPIO = 2'd1;
	localparam slave_idx_t S_RAM = 2'd2;
	localparam slave_idx_t S_INVALID = 2'd3;
	localparam int SLAVE_COUNT = 4;
	localparam int REAL_SLAVE_COUNT = 3;

	localparam int DEVTBL_MAPSZ = 16;
	localparam int GPIO_MAPSZ = 4;
	localparam int RAM_MAPSZ = 256;
	localparam int INVALID_MAPSZ = 1024;

	localparam addr_t DEVTBL_BASE = '0;
	localparam addr_t GPIO_BASE = DEVTBL_BASE + addr_t'(DEVTBL_MAPSZ);
	localparam addr_t RAM_BASE = GPIO_BASE + addr_t'(GPIO_MAPSZ);
	localparam addr_t INVALID_BASE = RAM_BASE + addr_t'(RAM_MAPSZ);

	// Device descriptors, indexed by slave
	localparam logic [15:0] DEVTBL_ID = 16'd7;
	localparam logic [15:0] GPIO_ID = 16'd6;
	localparam logic [15:0] RAM_ID = 16'd1;
	localparam logic [15:0] INVALID_ID = 16'd0;
	localparam logic [SLAVE_COUNT-1:0][15:0] DEV_ID = {INVALID_ID, RAM_ID, GPIO_ID, DEVTBL_ID};
	localparam logic [SLAVE_COUNT-1:0][31:0] DEV_MAPSZ = {
		32'(INVALID_MAPSZ), 32'(RAM_MAPSZ), 32'(GPIO_MAPSZ), 32'(DEVTBL_MAPSZ)
	};
	localparam logic [SLAVE_COUNT-1:0] USEINTR = 4'b0010;

	// ------------------------------------------------------------
	// Sizes and timing
	// ------------------------------------------------------------
	localparam int GPIO_COUNT = 16;
	localparam int RST_HOLD_CYCLES = 64;
	localparam int ACT_HOLDOFF = 127;
	localparam int RST_CNT_W = $clog2(RST_HOLD_CYCLES + 1);
	localparam int ACT_CNT_W = $clog2(ACT_HOLDOFF + 1);
	localparam int RAM_AW = $clog2(RAM_MAPSZ);

	typedef logic [GPIO_COUNT-1:0] gpio_t;
	typedef logic [RST_CNT_W-1:0] rst_cnt_t;
	typedef logic [ACT_CNT_W-1:0] act_cnt_t;
	typedef logic [RAM_AW-1:0] ram_addr_t;

	// Expands byte lane selects into a bit mask
	function automatic word_t sel_mask(sel_t sel);
		word_t m;
		m = '0;
		for (int b = 0; b < 4; b++) begin
			m[8*b +: 8] = {8{sel[b]}};
		end
		return m;
	endfunction

	function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t sel);
		word_t m;
		m = sel_mask(sel);
		return (old_w & ~m) | (new_w & m);
	endfunction

endpackage

/* source/soc_top.sv */
// System control part of the SoC on one clock; the PLL lock arrives as an input
// The GPIO interrupt goes straight out on gpio_irq_o as a level
`timescale 1ns/10ps

module soc_top (
	input logic clk100mhz,
	input logic rst_p,
	input logic pll_locked_i,
	input soc_pkg::pi1_op_e pi1_op_i,
	input soc_pkg::addr_t pi1_addr_i,
	input soc_pkg::word_t pi1_data_i,
	input soc_pkg::sel_t pi1_sel_i,
	input soc_pkg::gpio_t gp_i,
	output soc_pkg::word_t pi1_data_o,
	output logic pi1_rdy_o,
	output soc_pkg::gpio_t gp_o,
	output logic gpio_irq_o,
	output logic activity_o,
	output logic sys_rst_o
);

	soc_pkg::pi1_op_e s_op [soc_pkg::REAL_SLAVE_COUNT];
	soc_pkg::word_t s_data [soc_pkg::REAL_SLAVE_COUNT];
	soc_pkg::addr_t gpio_off;
	soc_pkg::addr_t ram_off;
	logic ram_rdy;
	logic rst0;
	logic rst1;
	logic rst2;

	// Slave-relative word offsets
	assign gpio_off = pi1_addr_i - soc_pkg::GPIO_BASE;
	assign ram_off = pi1_addr_i - soc_pkg::RAM_BASE;

	reset_ctrl u_reset_ctrl (
		.clk100mhz(clk100mhz),
		.rst_p(rst_p),
		.pll_locked_i(pll_locked_i),
		.poweroff_i(rst0),
		.warm_i(rst1),
		.sys_rst_o(sys_rst_o)
	);

	pi1_router u_router (
		.clk100mhz(clk100mhz),
		.rst_p(sys_rst_o),
		.m_op_i(pi1_op_i),
		.m_addr_i(pi1_addr_i),
		.m_data_i(pi1_data_i),
		.m_sel_i(pi1_sel_i),
		.m_data_o(pi1_data_o),
		.m_rdy_o(pi1_rdy_o),
		.s_op_o(s_op),
		.s_rdy_i({ram_rdy, 1'b1, 1'b1}),
		.s_data_i(s_data),
		.activity_o(activity_o)
	);

	dev_table u_dev_table (
		.clk100mhz(clk100mhz),
		.rst_p(sys_rst_o),
		.op_i(s_op[soc_pkg::S_DEVTBL]),
		.addr_lo_i(pi1_addr_i[3:0]),
		.data_i(pi1_data_i),
		.data_o(s_data[soc_pkg::S_DEVTBL]),
		.rst0_o(rst0),
		.rst1_o(rst1),
		.rst2_o(rst2)
	);

	gpio_port u_gpio (
		.clk100mhz(clk100mhz),
		.rst_p(sys_rst_o),
		.op_i(s_op[soc_pkg::S_GPIO]),
		.addr_lo_i(gpio_off[1:0]),
		.data_i(pi1_data_i),
		.sel_i(pi1_sel_i),
		.gp_i(gp_i),
		.data_o(s_data[soc_pkg::S_GPIO]),
		.gp_o(gp_o),
		.irq_o(gpio_irq_o)
	);

	scratch_ram u_ram (
		.clk100mhz(clk100mhz),
		.rst_p(sys_rst_o),
		.clear_i(rst2),
		.op_i(s_op[soc_pkg::S_RAM]),
		.addr_lo_i(ram_off[soc_pkg::RAM_AW-1:0]),
		.data_i(pi1_data_i),
		.sel_i(pi1_sel_i),
		.data_o(s_data[soc_pkg::S_RAM]),
		.rdy_o(ram_rdy)
	);

endmodule

/* sources.f */
source/soc_pkg.sv
source/reset_ctrl.sv
source/pi1_router.sv
source/dev_table.sv
source/gpio_port.sv
source/scratch_ram.sv
source/soc_top.sv
dv/soc_tb.sv
